/* alarm_clock.f */
src/alarm_clock_pkg.sv
src/tick_gen.sv
src/bcd_to_secs.sv
src/time_counter.sv
src/secs_to_bcd.sv
src/alarm.sv
src/alarm_clock_top.sv
verif/alarm_clock_props.sv
verif/alarm_clock_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module alarm_clock_tb -f alarm_clock.f -o sim_alarm_clock
./obj_dir/sim_alarm_clock > sim.log 2>&1 || true
cat sim.log
if grep -q 'Test failures found' sim.log; then
  echo "simulation FAILED"
  exit 1
fi
if ! grep -q 'All tests passed!' sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"

/* src/alarm.sv */
`timescale 1ns/1ns

module alarm import alarm_clock_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       alarm_load,
  input  secs_t      set_secs,
  input  alarm_sel_t alarm_sel,
  input  secs_t      now_secs,
  input  logic       sec_strobe,
  input  logic       cancel,
  output bcd2_t      alarm_hour_bcd,
  output bcd2_t      alarm_minute_bcd,
  output bcd2_t      alarm_second_bcd,
  output logic       ring
);

  secs_t       alarm_mem [3];
  secs_t       sel_secs;
  alarm_sel_t  sel_idx;
  logic        match;
  ring_state_t state;
  logic [3:0]  cnt;

  // index 3 maps onto alarm 0
  assign sel_idx = (alarm_sel == 2'd3) ? 2'd0 : alarm_sel;

  // alarm storage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      alarm_mem[0] <= ALARM0_RESET;
      alarm_mem[1] <= ALARM1_RESET;
      alarm_mem[2] <= ALARM2_RESET;
    end else if (alarm_load) begin
      alarm_mem[sel_idx] <= set_secs;
    end
  end

  // readback register in front of the converter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sel_secs <= ALARM0_RESET;
    end else begin
      sel_secs <= alarm_mem[sel_idx];
    end
  end

  secs_to_bcd alarm_disp0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .secs       (sel_secs),
    .hour_bcd   (alarm_hour_bcd),
    .minute_bcd (alarm_minute_bcd),
    .second_bcd (alarm_second_bcd)
  );

  // only on the strobe, so each second matches once
  assign match = sec_strobe && ((now_secs == alarm_mem[0]) ||
                                (now_secs == alarm_mem[1]) ||
                                (now_secs == alarm_mem[2]));

  // ring pattern, a new match restarts it even over cancel
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= RING_IDLE;
      cnt   <= '0;
    end else if (match) begin
      state <= RING_ON1;
      cnt   <= '0;
    end else if (cancel) begin
      state <= RING_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        RING_ON1: begin
          if (cnt == 4'(RING_ON_CYCLES - 1)) begin
            state <= RING_GAP;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        RING_GAP: begin
          if (cnt == 4'(RING_GAP_CYCLES - 1)) begin
            state <= RING_ON2;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        RING_ON2: begin
          if (cnt == 4'(RING_ON_CYCLES - 1)) begin
            state <= RING_IDLE;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          state <= RING_IDLE;
          cnt   <= '0;
        end
      endcase
    end
  end

  // high during either burst
  assign ring = (state == RING_ON1) || (state == RING_ON2);

endmodule

/* src/alarm_clock_pkg.sv */
package alarm_clock_pkg;

  // time of day in seconds, 0 to 86399
  typedef logic [16:0] secs_t;

  // two bcd digits for hour, minute or second
  typedef logic [7:0] bcd2_t;

  // alarm index, 3 falls back to alarm 0
  typedef logic [1:0] alarm_sel_t;

  // burst, gap, burst
  typedef enum logic [1:0] {
    RING_IDLE,
    RING_ON1,
    RING_GAP,
    RING_ON2
  } ring_state_t;

  localparam int SECS_PER_DAY = 86400;

  // 06:00:00, 07:30:00, 23:59:59
  localparam secs_t ALARM0_RESET = 17'd21600;
  localparam secs_t ALARM1_RESET = 17'd27000;
  localparam secs_t ALARM2_RESET = 17'd86399;

  // ring pattern lengths in clock cycles
  localparam int RING_ON_CYCLES  = 5;
  localparam int RING_GAP_CYCLES = 10;

endpackage

/* src/alarm_clock_top.sv */
`timescale 1ns/1ns

module alarm_clock_top import alarm_clock_pkg::*; #(
  parameter int CLKS_PER_SEC = 50_000_000
) (
  input  logic       clk,
  input  logic       rst_n,
  input  bcd2_t      set_hour_bcd,
  input  bcd2_t      set_minute_bcd,
  input  bcd2_t      set_second_bcd,
  input  logic       time_set,
  input  logic       alarm_set,
  input  alarm_sel_t alarm_sel,
  input  logic       cancel,
  output bcd2_t      time_hour_bcd,
  output bcd2_t      time_minute_bcd,
  output bcd2_t      time_second_bcd,
  output bcd2_t      alarm_hour_bcd,
  output bcd2_t      alarm_minute_bcd,
  output bcd2_t      alarm_second_bcd,
  output logic       ring
);

  logic  sec_tick;
  logic  sec_strobe;
  logic  time_load;
  logic  alarm_load;
  secs_t set_secs;
  secs_t now_secs;

  tick_gen #(
    .CLKS_PER_SEC (CLKS_PER_SEC)
  ) tick_gen0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .sec_tick (sec_tick)
  );

  // shared set path for time and alarm requests
  bcd_to_secs bcd_to_secs0 (
    .set_hour_bcd   (set_hour_bcd),
    .set_minute_bcd (set_minute_bcd),
    .set_second_bcd (set_second_bcd),
    .time_set       (time_set),
    .alarm_set      (alarm_set),
    .set_secs       (set_secs),
    .time_load      (time_load),
    .alarm_load     (alarm_load)
  );

  time_counter time_counter0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .sec_tick   (sec_tick),
    .time_load  (time_load),
    .set_secs   (set_secs),
    .now_secs   (now_secs),
    .sec_strobe (sec_strobe)
  );

  // time display, two cycles behind now_secs
  secs_to_bcd time_disp0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .secs       (now_secs),
    .hour_bcd   (time_hour_bcd),
    .minute_bcd (time_minute_bcd),
    .second_bcd (time_second_bcd)
  );

  alarm alarm0 (
    .clk              (clk),
    .rst_n            (rst_n),
    .alarm_load       (alarm_load),
    .set_secs         (set_secs),
    .alarm_sel        (alarm_sel),
    .now_secs         (now_secs),
    .sec_strobe       (sec_strobe),
    .cancel           (cancel),
    .alarm_hour_bcd   (alarm_hour_bcd),
    .alarm_minute_bcd (alarm_minute_bcd),
    .alarm_second_bcd (alarm_second_bcd),
    .ring             (ring)
  );

endmodule

/* src/bcd_to_secs.sv */
`timescale 1ns/1ns

module bcd_to_secs import alarm_clock_pkg::*; (
  input  bcd2_t set_hour_bcd,
  input  bcd2_t set_minute_bcd,
  input  bcd2_t set_second_bcd,
  input  logic  time_set,
  input  logic  alarm_set,
  output secs_t set_secs,
  output logic  time_load,
  output logic  alarm_load
);

  logic [3:0] hour_t, hour_o, min_t, min_o, sec_t, sec_o;
  logic       digits_ok;
  logic       range_ok;
  logic       valid;

  assign hour_t = set_hour_bcd[7:4];
  assign hour_o = set_hour_bcd[3:0];
  assign min_t  = set_minute_bcd[7:4];
  assign min_o  = set_minute_bcd[3:0];
  assign sec_t  = set_second_bcd[7:4];
  assign sec_o  = set_second_bcd[3:0];

  // each digit must be decimal
  assign digits_ok = (hour_t <= 4'd9) && (hour_o <= 4'd9) && (min_t <= 4'd9) &&
                     (min_o <= 4'd9) && (sec_t <= 4'd9) && (sec_o <= 4'd9);

  // hours up to 23, minutes and seconds up to 59
  assign range_ok = ((hour_t < 4'd2) || ((hour_t == 4'd2) && (hour_o <= 4'd3))) &&
                    (min_t <= 4'd5) && (sec_t <= 4'd5);

  assign valid = digits_ok && range_ok;

  // h*3600 + m*60 + s, each field from its two digits
  assign set_secs = (secs_t'(hour_t) * 17'd36000) + (secs_t'(hour_o) * 17'd3600) +
                    (secs_t'(min_t) * 17'd600) + (secs_t'(min_o) * 17'd60) +
                    (secs_t'(sec_t) * 17'd10) + secs_t'(sec_o);

  // bad input drops the request
  assign time_load  = time_set && valid;
  assign alarm_load = alarm_set && valid;

endmodule

/* src/secs_to_bcd.sv */
`timescale 1ns/1ns

module secs_to_bcd import alarm_clock_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  secs_t secs,
  output bcd2_t hour_bcd,
  output bcd2_t minute_bcd,
  output bcd2_t second_bcd
);

  logic [4:0]  hour_d, hour_q;
  logic [5:0]  min_d, min_q;
  logic [5:0]  sec_d, sec_q;
  logic [11:0] rem_hour;

  // binary 0..99 to two bcd digits
  function automatic bcd2_t bin_to_bcd(input logic [6:0] v);
    logic [3:0] tens;
    logic [3:0] ones;
    tens = 4'(v / 7'd10);
    ones = 4'(v % 7'd10);
    return {tens, ones};
  endfunction

  // stage one, split by constant division
  assign hour_d   = 5'(secs / 17'd3600);
  assign rem_hour = 12'(secs % 17'd3600);
  assign min_d    = 6'(rem_hour / 12'd60);
  assign sec_d    = 6'(rem_hour % 12'd60);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hour_q <= '0;
      min_q  <= '0;
      sec_q  <= '0;
    end else begin
      hour_q <= hour_d;
      min_q  <= min_d;
      sec_q  <= sec_d;
    end
  end

  // stage two, to bcd
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hour_bcd   <= '0;
      minute_bcd <= '0;
      second_bcd <= '0;
    end else begin
      hour_bcd   <= bin_to_bcd({2'b00, hour_q});
      minute_bcd <= bin_to_bcd({1'b0, min_q});
      second_bcd <= bin_to_bcd({1'b0, sec_q});
    end
  end

endmodule

/* src/tick_gen.sv */
`timescale 1ns/1ns

module tick_gen #(
  parameter int CLKS_PER_SEC = 50_000_000
) (
  input  logic clk,
  input  logic rst_n,
  output logic sec_tick
);

  // at least one bit, even for a divide by one
  localparam int CNT_W = (CLKS_PER_SEC > 1) ? $clog2(CLKS_PER_SEC) : 1;

  logic [CNT_W-1:0] cnt;

  // count 0 .. CLKS_PER_SEC-1, pulse on the wrap
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt      <= '0;
      sec_tick <= 1'b0;
    end else begin
      if (cnt == CNT_W'(CLKS_PER_SEC - 1)) begin
        cnt      <= '0;
        sec_tick <= 1'b1;
      end else begin
        cnt      <= cnt + 1'b1;
        sec_tick <= 1'b0;
      end
    end
  end

endmodule

/* src/time_counter.sv */
`timescale 1ns/1ns

module time_counter import alarm_clock_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  sec_tick,
  input  logic  time_load,
  input  secs_t set_secs,
  output secs_t now_secs,
  output logic  sec_strobe
);

  secs_t next_secs;

  // wrap at midnight
  assign next_secs = (now_secs == secs_t'(SECS_PER_DAY - 1)) ? '0 : now_secs + 1'b1;

  // load wins over tick, and a load does not raise the strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      now_secs   <= '0;
      sec_strobe <= 1'b0;
    end else begin
      if (time_load) begin
        now_secs   <= set_secs;
        sec_strobe <= 1'b0;
      end else if (sec_tick) begin
        now_secs   <= next_secs;
        sec_strobe <= 1'b1;
      end else begin
        sec_strobe <= 1'b0;
      end
    end
  end

endmodule

/* verif/alarm_clock_props.sv */
`timescale 1ns/1ns

module alarm_clock_props import alarm_clock_pkg::*; (
  input logic  clk,
  input logic  rst_n,
  input logic  cancel,
  input logic  match,
  input logic  ring,
  input bcd2_t time_second_bcd
);

  int error_count = 0;
  int high_len;

  // length of the current run of ring high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      high_len <= 0;
    end else begin
      high_len <= ring ? high_len + 1 : 0;
    end
  end

  ring_low_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !ring)
    else begin
      error_count++;
      $error("ring high in the cycle after reset release");
    end

  // a burst that was not cut by cancel lasts exactly RING_ON_CYCLES
  burst_length: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(ring) && !$past(cancel) |-> high_len == RING_ON_CYCLES)
    else begin
      error_count++;
      $error("ring burst of %0d cycles", high_len);
    end

  cancel_silences: assert property (@(posedge clk) disable iff (!rst_n)
    cancel && !match |=> !ring)
    else begin
      error_count++;
      $error("ring still high after cancel");
    end

  second_digits: assert property (@(posedge clk) disable iff (!rst_n)
    (time_second_bcd[7:4] <= 4'd9) && (time_second_bcd[3:0] <= 4'd9))
    else begin
      error_count++;
      $error("time_second_bcd holds a non-decimal digit");
    end

endmodule

bind alarm_clock_top alarm_clock_props props0 (
  .clk             (clk),
  .rst_n           (rst_n),
  .cancel          (cancel),
  .match           (alarm0.match),
  .ring            (ring),
  .time_second_bcd (time_second_bcd)
);

/* verif/alarm_clock_tb.sv */
`timescale 1ns/1ns

module alarm_clock_tb import alarm_clock_pkg::*; ();

  localparam int CLKS_PER_SEC    = 40;
  localparam int WATCHDOG_CYCLES = 2 * (3 * CLKS_PER_SEC + 400);
  localparam int RING_LEN        = 2 * RING_ON_CYCLES + RING_GAP_CYCLES;

  logic       clk;
  logic       rst_n;
  bcd2_t      set_hour_bcd;
  bcd2_t      set_minute_bcd;
  bcd2_t      set_second_bcd;
  logic       time_set;
  logic       alarm_set;
  alarm_sel_t alarm_sel;
  logic       cancel;
  bcd2_t      time_hour_bcd;
  bcd2_t      time_minute_bcd;
  bcd2_t      time_second_bcd;
  bcd2_t      alarm_hour_bcd;
  bcd2_t      alarm_minute_bcd;
  bcd2_t      alarm_second_bcd;
  logic       ring;

  // reference model state
  int          tick_cnt;
  int          ring_pos;
  logic        m_tick;
  logic        m_strobe;
  logic        hit;
  logic        req_time;
  logic        req_alarm;
  secs_t       req_secs;
  secs_t       m_secs, m_d1, m_d2;
  secs_t       m_rb1, m_rb2, m_rb3;
  secs_t       m_alarm [3];
  logic [31:0] lfsr;

  alarm_clock_top #(.CLKS_PER_SEC(CLKS_PER_SEC)) dut0 (.*);

  always #10 clk = ~clk;

  function automatic int alarm_index(input alarm_sel_t s);
    return (s == 2'd3) ? 0 : int'(s);
  endfunction

  function automatic bcd2_t to_bcd(input int v);
    return bcd2_t'(((v / 10) << 4) | (v % 10));
  endfunction

  function automatic int hours_of(input secs_t s);
    return int'(s) / 3600;
  endfunction

  function automatic int minutes_of(input secs_t s);
    return (int'(s) % 3600) / 60;
  endfunction

  function automatic int seconds_of(input secs_t s);
    return int'(s) % 60;
  endfunction

  // fibonacci lfsr on taps 32 22 2 1 stepped once per bit
  function automatic int random_bits(input int n);
    int   v;
    logic fb;
    v = 0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = (v << 1) | int'(fb);
    end
    return v;
  endfunction

  assign hit = m_strobe && ((m_secs == m_alarm[0]) || (m_secs == m_alarm[1]) ||
                            (m_secs == m_alarm[2]));

  // expected time, alarms, readback and ring position
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tick_cnt   <= 0;
      m_tick     <= 1'b0;
      m_secs     <= '0;
      m_strobe   <= 1'b0;
      m_d1       <= '0;
      m_d2       <= '0;
      m_alarm[0] <= ALARM0_RESET;
      m_alarm[1] <= ALARM1_RESET;
      m_alarm[2] <= ALARM2_RESET;
      m_rb1      <= ALARM0_RESET;
      m_rb2      <= '0;
      m_rb3      <= '0;
      ring_pos   <= 0;
    end else begin
      tick_cnt <= (tick_cnt == CLKS_PER_SEC - 1) ? 0 : tick_cnt + 1;
      m_tick   <= (tick_cnt == CLKS_PER_SEC - 1);
      m_strobe <= !req_time && m_tick;
      if (req_time) begin
        m_secs <= req_secs;
      end else if (m_tick) begin
        m_secs <= (m_secs == secs_t'(SECS_PER_DAY - 1)) ? '0 : m_secs + 17'd1;
      end
      m_d1 <= m_secs;
      m_d2 <= m_d1;
      if (req_alarm) begin
        m_alarm[alarm_index(alarm_sel)] <= req_secs;
      end
      m_rb1 <= m_alarm[alarm_index(alarm_sel)];
      m_rb2 <= m_rb1;
      m_rb3 <= m_rb2;
      if (hit) begin
        ring_pos <= 1;
      end else if (cancel || ring_pos == RING_LEN) begin
        ring_pos <= 0;
      end else if (ring_pos != 0) begin
        ring_pos <= ring_pos + 1;
      end
    end
  end

  task automatic check_value(input string name, input int exp_v, input int act_v);
    assert (exp_v == act_v) else begin
      $display("CHECK FAILED at %0t ns: %s expected %0h actual %0h", $time, name, exp_v, act_v);
      $display("Test failures found");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // outputs are settled half a cycle after the edge
  always @(negedge clk) begin
    if (rst_n) begin
      check_value("time_hour_bcd", to_bcd(hours_of(m_d2)), int'(time_hour_bcd));
      check_value("time_minute_bcd", to_bcd(minutes_of(m_d2)), int'(time_minute_bcd));
      check_value("time_second_bcd", to_bcd(seconds_of(m_d2)), int'(time_second_bcd));
      check_value("alarm_hour_bcd", to_bcd(hours_of(m_rb3)), int'(alarm_hour_bcd));
      check_value("alarm_minute_bcd", to_bcd(minutes_of(m_rb3)), int'(alarm_minute_bcd));
      check_value("alarm_second_bcd", to_bcd(seconds_of(m_rb3)), int'(alarm_second_bcd));
      check_value("ring", int'((ring_pos >= 1 && ring_pos <= RING_ON_CYCLES) ||
                               (ring_pos > RING_ON_CYCLES + RING_GAP_CYCLES)), int'(ring));
    end
  end

  // a failed bound property stops the run at the next falling edge
  always @(negedge clk) begin
    if (dut0.props0.error_count != 0) begin
      $display("property failure at %0t ns: %0d bound assertions failed", $time,
               dut0.props0.error_count);
      $display("Test failures found");
      $fatal(1, "bound assertion failed");
    end
  end

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  // next second boundary as the model sees it
  task automatic wait_strobe();
    do begin
      wait_cycles(1);
    end while (!m_strobe);
  endtask

  task automatic send_request(input bcd2_t h, input bcd2_t m, input bcd2_t s, input logic t,
                              input logic a, input logic ok, input secs_t secs);
    set_hour_bcd   = h;
    set_minute_bcd = m;
    set_second_bcd = s;
    time_set       = t;
    alarm_set      = a;
    req_time       = t && ok;
    req_alarm      = a && ok;
    req_secs       = secs;
    wait_cycles(1);
    time_set  = 1'b0;
    alarm_set = 1'b0;
    req_time  = 1'b0;
    req_alarm = 1'b0;
  endtask

  task automatic request_time_of_day(input int h, input int m, input int s, input logic t,
                                     input logic a);
    send_request(to_bcd(h), to_bcd(m), to_bcd(s), t, a, 1'b1, secs_t'(h * 3600 + m * 60 + s));
  endtask

  initial begin
    int h;
    int m;
    int s;
    clk            = 1'b0;
    rst_n          = 1'b0;
    set_hour_bcd   = '0;
    set_minute_bcd = '0;
    set_second_bcd = '0;
    time_set       = 1'b0;
    alarm_set      = 1'b0;
    alarm_sel      = '0;
    cancel         = 1'b0;
    req_time       = 1'b0;
    req_alarm      = 1'b0;
    req_secs       = '0;
    lfsr           = 32'h0b95_6923;
    wait_cycles(5);
    rst_n = 1'b1;
    // reset values of all three alarms
    for (int i = 0; i < 3; i++) begin
      alarm_sel = alarm_sel_t'(i);
      wait_cycles(4);
    end
    // random valid alarm times and their readback including index 3
    for (int i = 0; i < 3; i++) begin
      h = random_bits(5) % 24;
      m = random_bits(6) % 60;
      s = random_bits(6) % 60;
      alarm_sel = alarm_sel_t'(i);
      request_time_of_day(h, m, s, 1'b0, 1'b1);
    end
    for (int i = 3; i >= 0; i--) begin
      alarm_sel = alarm_sel_t'(i);
      wait_cycles(4);
    end
    // hour 24 and a non-decimal digit are both dropped
    send_request(8'h24, 8'h00, 8'h00, 1'b1, 1'b1, 1'b0, '0);
    send_request(8'h12, 8'h5a, 8'h00, 1'b1, 1'b1, 1'b0, '0);
    wait_cycles(4);
    // count across midnight
    request_time_of_day(23, 59, 58, 1'b1, 1'b0);
    wait_strobe();
    wait_cycles(2);
    wait_strobe();
    wait_cycles(2);
    // full ring pattern from alarm 1
    alarm_sel = 2'd1;
    request_time_of_day(10, 0, 1, 1'b0, 1'b1);
    request_time_of_day(10, 0, 0, 1'b1, 1'b0);
    wait_strobe();
    wait_cycles(RING_LEN + 5);
    // cancel in the first burst of alarm 2
    alarm_sel = 2'd2;
    request_time_of_day(12, 0, 1, 1'b0, 1'b1);
    request_time_of_day(12, 0, 0, 1'b1, 1'b0);
    wait_strobe();
    wait_cycles(2);
    cancel = 1'b1;
    wait_cycles(1);
    cancel = 1'b0;
    wait_cycles(RING_LEN + 5);
    if (dut0.props0.error_count == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("Test failures found");
      $fatal(1, "%0d property failures", dut0.props0.error_count);
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * 20);
    $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Test failures found");
    $fatal(1, "watchdog expired");
  end

endmodule
